/* all.f */
core_shell_pkg.sv
gpio_config_regs.sv
run_controller.sv
data_mem_port.sv
inst_mem_port.sv
core_shell_top.sv
core_shell_sva.sv
tb_clock_gen.sv
tb_checker.sv
tb_core_shell.sv

/* core_shell_pkg.sv */
`default_nettype none

package core_shell_pkg;

    // data or address word
    typedef logic [31:0] xlen_t;
    // byte lane write enable
    typedef logic [3:0]  byte_en_t;
    // gpio control word, one bit per command
    typedef logic [31:0] ctrl_word_t;
    // fetch wait and recovery counters
    typedef logic [3:0]  wait_cnt_t;

    localparam int unsigned CTRL_START_BIT = 0;
    localparam int unsigned CTRL_RESET_BIT = 1;

    // result-matching cycles before the run stops
    localparam int unsigned DRAIN_CYCLES   = 30;
    // held request cycles up to the fetch grant
    localparam int unsigned GRANT_WAIT     = 2;
    // idle cycles after a fetch grant
    localparam int unsigned RECOVER_CYCLES = 1;

    typedef struct packed {
        logic     req;
        xlen_t    addr;
        logic     we;
        byte_en_t be;
        xlen_t    wdata;
    } mem_req_t;

    typedef struct packed {
        xlen_t rdata;
        logic  gnt;
        logic  rvalid;
    } mem_rsp_t;

    typedef struct packed {
        logic     enb;
        byte_en_t web;
        xlen_t    addrb;
        xlen_t    dinb;
    } dbram_t;

    typedef struct packed {
        logic  enb;
        xlen_t addrb;
    } ibram_t;

    typedef struct packed {
        xlen_t mem_offset;
        xlen_t boot_pc;
        xlen_t success_code;
    } run_cfg_t;

    typedef enum logic {
        COUNTING,
        RECOVERING
    } run_state_t;

endpackage

`default_nettype wire

/* core_shell_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module core_shell_sva import core_shell_pkg::*; (
    input logic     clk_i,
    input logic     reset_i,
    input mem_rsp_t rsp_i,
    input logic     spaced_gnt_i
);

    // fetch grants are kept apart by the recovery gap
    gnt_spacing: assert property (
        @(posedge clk_i) disable iff (reset_i)
        spaced_gnt_i && rsp_i.gnt |=> !rsp_i.gnt
    ) else $error("grant in the cycle right after a grant");

    // read data returns one cycle after a grant
    rvalid_after_gnt: assert property (
        @(posedge clk_i) disable iff (reset_i) rsp_i.gnt |=> rsp_i.rvalid
    ) else $error("no rvalid one cycle after grant");

    // and never without one
    no_stray_rvalid: assert property (
        @(posedge clk_i) disable iff (reset_i) !rsp_i.gnt |=> !rsp_i.rvalid
    ) else $error("rvalid without a grant in the cycle before");

endmodule

bind data_mem_port core_shell_sva u_sva (
    .clk_i        (clk),
    .reset_i      (reset),
    .rsp_i        (rsp_o),
    .spaced_gnt_i (1'b0)
);

bind inst_mem_port core_shell_sva u_sva (
    .clk_i        (clk),
    .reset_i      (reset),
    .rsp_i        (rsp_o),
    .spaced_gnt_i (1'b1)
);

`default_nettype wire

/* core_shell_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_shell_top import core_shell_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t gpio_ctrl_i,
    input  xlen_t      gpio_offset_i,
    input  xlen_t      gpio_boot_pc_i,
    input  xlen_t      gpio_success_i,
    input  xlen_t      core_result_i,
    input  mem_req_t   data_req_i,
    input  mem_req_t   inst_req_i,
    input  xlen_t      dbram_dout_i,
    input  xlen_t      ibram_dout_i,
    output mem_rsp_t   data_rsp_o,
    output mem_rsp_t   inst_rsp_o,
    output dbram_t     dbram_o,
    output ibram_t     ibram_o,
    output logic       run_enable_o,
    output logic       stop_o,
    output xlen_t      cycle_count_o,
    output xlen_t      boot_pc_o
);

    logic     start_pulse;
    logic     soft_reset_pulse;
    run_cfg_t cfg;

    // boot pc goes out to the core
    assign boot_pc_o = cfg.boot_pc;

    gpio_config_regs u_gpio_config_regs (
        .clk          (clk),
        .reset        (reset),
        .ctrl_i       (gpio_ctrl_i),
        .offset_i     (gpio_offset_i),
        .boot_pc_i    (gpio_boot_pc_i),
        .success_i    (gpio_success_i),
        .start_o      (start_pulse),
        .soft_reset_o (soft_reset_pulse),
        .cfg_o        (cfg)
    );

    run_controller u_run_controller (
        .clk            (clk),
        .reset          (reset),
        .start_i        (start_pulse),
        .soft_reset_i   (soft_reset_pulse),
        .result_i       (core_result_i),
        .success_code_i (cfg.success_code),
        .run_enable_o   (run_enable_o),
        .stop_o         (stop_o),
        .cycle_count_o  (cycle_count_o)
    );

    data_mem_port u_data_mem_port (
        .clk          (clk),
        .reset        (reset),
        .run_enable_i (run_enable_o),
        .mem_offset_i (cfg.mem_offset),
        .req_i        (data_req_i),
        .dout_i       (dbram_dout_i),
        .rsp_o        (data_rsp_o),
        .bram_o       (dbram_o)
    );

    inst_mem_port u_inst_mem_port (
        .clk          (clk),
        .reset        (reset),
        .run_enable_i (run_enable_o),
        .req_i        (inst_req_i),
        .dout_i       (ibram_dout_i),
        .rsp_o        (inst_rsp_o),
        .bram_o       (ibram_o)
    );

endmodule

`default_nettype wire

/* data_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem_port import core_shell_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     run_enable_i,
    input  xlen_t    mem_offset_i,
    input  mem_req_t req_i,
    input  xlen_t    dout_i,
    output mem_rsp_t rsp_o,
    output dbram_t   bram_o
);

    logic     accepted;
    logic     rvalid_q;
    byte_en_t write_lanes;

    // requests only count while the run is enabled
    assign accepted    = req_i.req & run_enable_i;
    assign write_lanes = (accepted && req_i.we) ? req_i.be : '0;

    // bram holds data relative to the configured offset
    assign bram_o = '{
        enb:   accepted,
        web:   write_lanes,
        addrb: req_i.addr - mem_offset_i,
        dinb:  req_i.wdata
    };

    // grant in the request cycle, read data straight from the bram
    assign rsp_o = '{
        rdata:  dout_i,
        gnt:    accepted,
        rvalid: rvalid_q
    };

    // one-cycle read latency, back-to-back requests pipeline through
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= accepted;
        end
    end

endmodule

`default_nettype wire

/* gpio_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_config_regs import core_shell_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t ctrl_i,
    input  xlen_t      offset_i,
    input  xlen_t      boot_pc_i,
    input  xlen_t      success_i,
    output logic       start_o,
    output logic       soft_reset_o,
    output run_cfg_t   cfg_o
);

    // last sampled level of the two command bits
    logic prev_start;
    logic prev_soft_reset;

    // rising edge detect, pulse lasts one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_start      <= 1'b0;
            prev_soft_reset <= 1'b0;
            start_o         <= 1'b0;
            soft_reset_o    <= 1'b0;
        end else begin
            prev_start      <= ctrl_i[CTRL_START_BIT];
            prev_soft_reset <= ctrl_i[CTRL_RESET_BIT];
            start_o         <= ctrl_i[CTRL_START_BIT] & ~prev_start;
            soft_reset_o    <= ctrl_i[CTRL_RESET_BIT] & ~prev_soft_reset;
        end
    end

    // configuration words, one cycle behind the gpio inputs
    always_ff @(posedge clk) begin
        cfg_o.mem_offset   <= offset_i;
        cfg_o.boot_pc      <= boot_pc_i;
        cfg_o.success_code <= success_i;
    end

endmodule

`default_nettype wire

/* inst_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_mem_port import core_shell_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     run_enable_i,
    input  mem_req_t req_i,
    input  xlen_t    dout_i,
    output mem_rsp_t rsp_o,
    output ibram_t   bram_o
);

    run_state_t state;
    wait_cnt_t  wait_cnt;
    wait_cnt_t  recover_cnt;
    logic       accepted;
    logic       grant;
    logic       rvalid_q;

    // read-only port, write fields of the request are ignored
    assign accepted = req_i.req & run_enable_i;
    assign grant    = (state == COUNTING) && accepted
                      && (wait_cnt == wait_cnt_t'(GRANT_WAIT - 1));

    assign bram_o = '{enb: grant, addrb: req_i.addr};
    assign rsp_o  = '{rdata: dout_i, gnt: grant, rvalid: rvalid_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= COUNTING;
            wait_cnt    <= '0;
            recover_cnt <= '0;
            rvalid_q    <= 1'b0;
        end else begin
            rvalid_q <= grant;
            case (state)
                COUNTING: begin
                    // count only held request cycles, hold otherwise
                    if (grant) begin
                        wait_cnt    <= '0;
                        recover_cnt <= '0;
                        state       <= RECOVERING;
                    end else if (accepted) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                RECOVERING: begin
                    if (recover_cnt == wait_cnt_t'(RECOVER_CYCLES - 1)) begin
                        state <= COUNTING;
                    end else begin
                        recover_cnt <= recover_cnt + 1'b1;
                    end
                end
                default: state <= COUNTING;
            endcase
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator, log in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_core_shell \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_core_shell +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

/* run_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module run_controller import core_shell_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start_i,
    input  logic  soft_reset_i,
    input  xlen_t result_i,
    input  xlen_t success_code_i,
    output logic  run_enable_o,
    output logic  stop_o,
    output xlen_t cycle_count_o
);

    // enabled cycles with the core result at the success code
    xlen_t drain_count;
    logic  result_match;
    logic  drain_done;

    assign result_match = run_enable_o && (result_i == success_code_i);
    assign drain_done   = (drain_count >= DRAIN_CYCLES);

    always_ff @(posedge clk) begin
        if (reset || soft_reset_i) begin
            run_enable_o  <= 1'b0;
            stop_o        <= 1'b0;
            cycle_count_o <= '0;
            drain_count   <= '0;
        end else begin
            // a start restarts the cycle count from zero
            if (start_i) begin
                run_enable_o  <= 1'b1;
                cycle_count_o <= '0;
            end else if (run_enable_o) begin
                cycle_count_o <= cycle_count_o + 1'b1;
            end

            if (result_match) begin
                drain_count <= drain_count + 1'b1;
            end

            // end of run wins over a start in the same cycle
            if (drain_done) begin
                stop_o       <= 1'b1;
                run_enable_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import core_shell_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  ctrl_word_t  ctrl_i,
    input  xlen_t       offset_i,
    input  xlen_t       boot_pc_set_i,
    input  xlen_t       success_i,
    input  xlen_t       result_i,
    input  mem_req_t    data_req_i,
    input  mem_req_t    inst_req_i,
    input  mem_rsp_t    data_rsp_i,
    input  mem_rsp_t    inst_rsp_i,
    input  dbram_t      dbram_i,
    input  ibram_t      ibram_i,
    input  logic        run_enable_i,
    input  logic        stop_i,
    input  xlen_t       cycle_count_i,
    input  xlen_t       boot_pc_i,
    output int unsigned check_count_o,
    output int unsigned error_count_o
);

    // reference state, advanced once per cycle
    ctrl_word_t  prev_ctrl;
    logic        start_p;
    logic        srst_p;
    xlen_t       cfg_offset;
    xlen_t       cfg_boot;
    xlen_t       cfg_success;
    logic        exp_en;
    logic        exp_stop;
    xlen_t       exp_count;
    xlen_t       drain;
    logic        data_acc_q;
    logic        read_pending;
    xlen_t       read_word;
    int unsigned fetch_cnt;
    int unsigned recover_left;
    logic        fetch_gnt_q;
    xlen_t       fetch_word;
    xlen_t       shadow [64];

    // same fill as the testbench bram, every address bit shows up
    function automatic xlen_t fill_word(int unsigned idx);
        return {4{2'b10, idx[5:0]}};
    endfunction

    // expected data bram port for one request
    function automatic dbram_t expect_dbram(mem_req_t req, logic en, xlen_t offset);
        dbram_t port;
        port.enb   = req.req & en;
        port.web   = (port.enb && req.we) ? req.be : 4'h0;
        port.addrb = req.addr - offset;
        port.dinb  = req.wdata;
        return port;
    endfunction

    task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
        check_count_o++;
        if (got !== exp) begin
            error_count_o++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        check_count_o = 0;
        error_count_o = 0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = fill_word(i);
        end
    end

    // inputs change just after the rising edge, so the falling edge is stable
    always @(negedge clk_i) begin
        dbram_t     exp_bram;
        logic       fetch_gnt;
        logic       stop_now;
        logic [5:0] idx;
        exp_bram  = expect_dbram(data_req_i, exp_en, cfg_offset);
        fetch_gnt = (recover_left == 0) && inst_req_i.req && exp_en
                    && (fetch_cnt == GRANT_WAIT - 1);
        idx       = exp_bram.addrb[7:2];
        if (!reset_i) begin
            compare_value("run_enable_o", xlen_t'(run_enable_i), xlen_t'(exp_en));
            compare_value("stop_o", xlen_t'(stop_i), xlen_t'(exp_stop));
            compare_value("cycle_count_o", cycle_count_i, exp_count);
            compare_value("boot_pc_o", boot_pc_i, cfg_boot);
            compare_value("data_rsp_o.gnt", xlen_t'(data_rsp_i.gnt), xlen_t'(exp_bram.enb));
            compare_value("data_rsp_o.rvalid", xlen_t'(data_rsp_i.rvalid), xlen_t'(data_acc_q));
            compare_value("dbram_o.enb", xlen_t'(dbram_i.enb), xlen_t'(exp_bram.enb));
            compare_value("dbram_o.web", xlen_t'(dbram_i.web), xlen_t'(exp_bram.web));
            compare_value("dbram_o.addrb", dbram_i.addrb, exp_bram.addrb);
            compare_value("dbram_o.dinb", dbram_i.dinb, exp_bram.dinb);
            if (data_acc_q && read_pending) begin
                compare_value("data_rsp_o.rdata", data_rsp_i.rdata, read_word);
            end
            compare_value("inst_rsp_o.gnt", xlen_t'(inst_rsp_i.gnt), xlen_t'(fetch_gnt));
            compare_value("ibram_o.enb", xlen_t'(ibram_i.enb), xlen_t'(fetch_gnt));
            compare_value("inst_rsp_o.rvalid", xlen_t'(inst_rsp_i.rvalid), xlen_t'(fetch_gnt_q));
            compare_value("ibram_o.addrb", ibram_i.addrb, inst_req_i.addr);
            if (fetch_gnt_q) begin
                compare_value("inst_rsp_o.rdata", inst_rsp_i.rdata, fetch_word);
            end
        end
        if (reset_i) begin
            prev_ctrl    = '0;
            start_p      = 1'b0;
            srst_p       = 1'b0;
            exp_en       = 1'b0;
            exp_stop     = 1'b0;
            exp_count    = '0;
            drain        = '0;
            data_acc_q   = 1'b0;
            read_pending = 1'b0;
            fetch_cnt    = 0;
            recover_left = 0;
            fetch_gnt_q  = 1'b0;
        end else begin
            // run control uses the pulses and config of this cycle
            if (srst_p) begin
                exp_en    = 1'b0;
                exp_stop  = 1'b0;
                exp_count = '0;
                drain     = '0;
            end else begin
                stop_now = (drain >= DRAIN_CYCLES);
                if (exp_en && result_i == cfg_success) begin
                    drain++;
                end
                if (start_p) begin
                    exp_en    = 1'b1;
                    exp_count = '0;
                end else if (exp_en) begin
                    exp_count++;
                end
                if (stop_now) begin
                    exp_stop = 1'b1;
                    exp_en   = 1'b0;
                end
            end
            start_p   = ctrl_i[CTRL_START_BIT] && !prev_ctrl[CTRL_START_BIT];
            srst_p    = ctrl_i[CTRL_RESET_BIT] && !prev_ctrl[CTRL_RESET_BIT];
            prev_ctrl = ctrl_i;
            // data bram reads before it writes
            data_acc_q   = exp_bram.enb;
            read_pending = exp_bram.enb && !data_req_i.we;
            if (exp_bram.enb) begin
                read_word = shadow[idx];
                for (int b = 0; b < 4; b++) begin
                    if (exp_bram.web[b]) begin
                        shadow[idx][8*b +: 8] = data_req_i.wdata[8*b +: 8];
                    end
                end
            end
            // fetch grant then recovery gap
            fetch_gnt_q = fetch_gnt;
            if (fetch_gnt) begin
                // instruction bram holds the inverted fill
                fetch_word = ~fill_word(inst_req_i.addr[7:2]);
            end
            if (recover_left != 0) begin
                recover_left--;
            end else if (fetch_gnt) begin
                fetch_cnt    = 0;
                recover_left = RECOVER_CYCLES;
            end else if (inst_req_i.req && exp_en) begin
                fetch_cnt++;
            end
        end
        cfg_offset  = offset_i;
        cfg_boot    = boot_pc_set_i;
        cfg_success = success_i;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int unsigned HALF_PERIOD  = 4;
    localparam int unsigned RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset released just after an edge, like the other stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_core_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_shell import core_shell_pkg::*; ();

    localparam int unsigned RESET_CYCLES    = 10;
    localparam int unsigned PRESTART_CYCLES = 6;
    localparam int unsigned COUNT_CYCLES    = 30;
    localparam int unsigned RANDOM_CYCLES   = 400;
    localparam int unsigned DRAIN_PHASE     = 40;
    localparam int unsigned END_CYCLES      = 14;
    localparam int unsigned TEST_CYCLES     = RESET_CYCLES + PRESTART_CYCLES + COUNT_CYCLES
                                              + RANDOM_CYCLES + DRAIN_PHASE + END_CYCLES;
    // generous margin over the scripted length
    localparam int unsigned TIMEOUT_CYCLES  = 4 * TEST_CYCLES;

    logic        clk;
    logic        reset;
    ctrl_word_t  gpio_ctrl;
    xlen_t       gpio_offset;
    xlen_t       gpio_boot_pc;
    xlen_t       gpio_success;
    xlen_t       core_result;
    mem_req_t    data_req;
    mem_req_t    inst_req;
    xlen_t       dbram_dout;
    xlen_t       ibram_dout;
    mem_rsp_t    data_rsp;
    mem_rsp_t    inst_rsp;
    dbram_t      dbram;
    ibram_t      ibram;
    logic        run_enable;
    logic        stop;
    xlen_t       cycle_count;
    xlen_t       boot_pc;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned cycle_num;
    xlen_t       lfsr_state;
    xlen_t       dmem [64];
    xlen_t       imem [64];

    tb_clock_gen u_clock_gen (.clk_o(clk), .reset_o(reset));

    core_shell_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .gpio_ctrl_i    (gpio_ctrl),
        .gpio_offset_i  (gpio_offset),
        .gpio_boot_pc_i (gpio_boot_pc),
        .gpio_success_i (gpio_success),
        .core_result_i  (core_result),
        .data_req_i     (data_req),
        .inst_req_i     (inst_req),
        .dbram_dout_i   (dbram_dout),
        .ibram_dout_i   (ibram_dout),
        .data_rsp_o     (data_rsp),
        .inst_rsp_o     (inst_rsp),
        .dbram_o        (dbram),
        .ibram_o        (ibram),
        .run_enable_o   (run_enable),
        .stop_o         (stop),
        .cycle_count_o  (cycle_count),
        .boot_pc_o      (boot_pc)
    );

    tb_checker u_checker (
        .clk_i         (clk),
        .reset_i       (reset),
        .ctrl_i        (gpio_ctrl),
        .offset_i      (gpio_offset),
        .boot_pc_set_i (gpio_boot_pc),
        .success_i     (gpio_success),
        .result_i      (core_result),
        .data_req_i    (data_req),
        .inst_req_i    (inst_req),
        .data_rsp_i    (data_rsp),
        .inst_rsp_i    (inst_rsp),
        .dbram_i       (dbram),
        .ibram_i       (ibram),
        .run_enable_i  (run_enable),
        .stop_i        (stop),
        .cycle_count_i (cycle_count),
        .boot_pc_i     (boot_pc),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    // bram models with one cycle read latency, read before write
    always @(posedge clk) begin
        if (dbram.enb) begin
            dbram_dout <= dmem[dbram.addrb[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (dbram.web[b]) begin
                    dmem[dbram.addrb[7:2]][8*b +: 8] <= dbram.dinb[8*b +: 8];
                end
            end
        end
        if (ibram.enb) begin
            ibram_dout <= imem[ibram.addrb[7:2]];
        end
    end

    function automatic xlen_t lfsr_next(xlen_t s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int unsigned n, output xlen_t value);
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_data_req();
        xlen_t bits;
        take_bits(1, bits);
        data_req.req = bits[0];
        take_bits(1, bits);
        data_req.we = bits[0];
        take_bits(4, bits);
        data_req.be = bits[3:0];
        take_bits(6, bits);
        data_req.addr = gpio_offset + {24'b0, bits[5:0], 2'b00};
        take_bits(32, bits);
        data_req.wdata = bits;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_num <= cycle_num + 1;
        if (cycle_num >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {4{2'b10, i[5:0]}};
            imem[i] = ~{4{2'b10, i[5:0]}};
        end
        cycle_num    = 0;
        lfsr_state   = 32'hd165;
        dbram_dout   = '0;
        ibram_dout   = '0;
        gpio_ctrl    = '0;
        gpio_offset  = 32'h0000_4000;
        gpio_boot_pc = 32'h0000_0100;
        gpio_success = 32'h600d_c0de;
        core_result  = '0;
        data_req     = '0;
        inst_req     = '0;
        wait (!reset);
        // requests before start must stay ungranted
        repeat (PRESTART_CYCLES) begin
            random_data_req();
            next_cycle();
        end
        data_req = '0;
        gpio_ctrl[CTRL_START_BIT] = 1'b1;
        repeat (COUNT_CYCLES / 2) next_cycle();
        gpio_ctrl[CTRL_START_BIT] = 1'b0;
        next_cycle();
        // second edge restarts the count
        gpio_ctrl[CTRL_START_BIT] = 1'b1;
        repeat (COUNT_CYCLES / 2) next_cycle();
        inst_req.addr = 32'h0000_0080;
        for (int unsigned i = 0; i < RANDOM_CYCLES; i++) begin
            random_data_req();
            // short gap in the fetch request, the wait count holds
            inst_req.req = !(i >= 200 && i < 205);
            if (i == RANDOM_CYCLES / 2) begin
                inst_req.addr = 32'h0000_00c4;
            end
            next_cycle();
        end
        data_req    = '0;
        inst_req    = '0;
        core_result = gpio_success;
        repeat (DRAIN_PHASE) next_cycle();
        core_result = '0;
        gpio_ctrl[CTRL_RESET_BIT] = 1'b1;
        repeat (END_CYCLES) next_cycle();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count != 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
